// File: Makefile
# verilator build and run of the i/o controller testbench
VERILATOR ?= verilator
TOP       ?= user_io_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard src/*.sv src/*.svh tb/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
+incdir+src
src/io_pkg.sv
src/spi_frame.sv
src/cmd_decoder.sv
src/reply_mux.sv
src/byte_fifo.sv
src/user_io_top.sv
tb/user_io_props.sv
tb/user_io_tb.sv

// File: src/byte_fifo.sv
// byte queue with valid/ready on both sides
// circular buffer, one slot kept free, flush clears the pointers
`timescale 1ns/1ns
`include "io_defines.svh"

module byte_fifo #(
	parameter int DEPTH_BITS = `IO_QUEUE_BITS
) (
	input  logic                spi_sck,
	input  logic                flush,
	input  io_pkg::queue_beat_t in_beat,
	output logic                in_ready,
	output io_pkg::queue_beat_t out_beat,
	input  logic                out_ready
);

	logic [7:0]            mem [2**DEPTH_BITS];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	// bytes held, wraps with the pointers
	logic [DEPTH_BITS-1:0] count;

	assign count = wr_ptr - rd_ptr;

	// full at depth minus one so equal pointers always mean empty
	assign in_ready       = (count != {DEPTH_BITS{1'b1}});
	assign out_beat.valid = (count != '0);
	assign out_beat.data  = mem[rd_ptr];

	// pointers only come back to zero through a flush
	always_ff @(posedge spi_sck) begin
		if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (in_beat.valid && in_ready)
				wr_ptr <= wr_ptr + 1'b1;
			if (out_beat.valid && out_ready)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage, no reset
	always_ff @(posedge spi_sck) begin
		if (in_beat.valid && in_ready && !flush)
			mem[wr_ptr] <= in_beat.data;
	end

endmodule

// File: src/cmd_decoder.sv
// command decoder for host writes
// opcode latch, input state and status registers
// keyboard and mouse queue pushes
`timescale 1ns/1ns

module cmd_decoder (
	input  logic                 spi_sck,
	input  logic                 SPI_SS_IO,
	input  io_pkg::spi_byte_t    rx,
	output io_pkg::io_cmd_e      cmd,
	output io_pkg::input_state_t state,
	output logic [7:0]           status,
	output io_pkg::queue_beat_t  kbd_in,
	input  logic                 kbd_in_ready,
	output io_pkg::queue_beat_t  mouse_in,
	input  logic                 mouse_in_ready
);

	import io_pkg::*;

	// any byte after the opcode
	logic       payload;
	// analog stick selected by byte 1 of an analog write
	logic [7:0] stick_idx;

	assign payload = rx.valid && (rx.index != 8'd0);

	// opcode latch, cleared between transfers
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			cmd <= cmd_but_sw;
		else if (rx.valid && (rx.index == 8'd0))
			cmd <= io_cmd_e'(rx.data);
	end

	// settings live across transfers, the chip select must not clear them
	always_ff @(posedge spi_sck) begin
		if (payload) begin
			case (cmd)
				cmd_but_sw: begin
					state.buttons             <= rx.data[1:0];
					state.switches            <= rx.data[3:2];
					state.scandoubler_disable <= rx.data[4];
				end
				cmd_joy0:   state.joystick_0 <= rx.data;
				cmd_joy1:   state.joystick_1 <= rx.data;
				cmd_status: status <= rx.data;
				cmd_analog: begin
					if (rx.index == 8'd1) begin
						stick_idx <= rx.data;
					end else if (rx.index == 8'd2) begin
						// x axis
						if (stick_idx == 8'd0)
							state.joystick_analog_0[15:8] <= rx.data;
						else if (stick_idx == 8'd1)
							state.joystick_analog_1[15:8] <= rx.data;
					end else if (rx.index == 8'd3) begin
						// y axis
						if (stick_idx == 8'd0)
							state.joystick_analog_0[7:0] <= rx.data;
						else if (stick_idx == 8'd1)
							state.joystick_analog_1[7:0] <= rx.data;
					end
				end
				default: ;
			endcase
		end
	end

	// the host cannot be held off, so a byte for a full queue is dropped
	// pushes land on the same edge as the setting writes
	assign kbd_in.data    = rx.data;
	assign kbd_in.valid   = payload && (cmd == cmd_kbd) && kbd_in_ready;
	assign mouse_in.data  = rx.data;
	assign mouse_in.valid = payload && (cmd == cmd_mouse) && mouse_in_ready;

endmodule

// File: src/io_defines.svh
// shared constants for the i/o controller
// core type byte, input queue depth and the configuration string
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// core type sent back while the opcode byte shifts in
// a4 marks an 8 bit core
`define IO_CORE_TYPE 8'ha4

// log2 of the keyboard and mouse queue depth
// one slot stays empty, so 3 gives seven usable entries
`define IO_QUEUE_BITS 3

// menu description read by the io controller with cmd_conf_rd
// IO_CONF_LEN has to match the string length in bytes
`define IO_CONF_STR "RETRO;;O2,Scanlines,Off,On;T1,Reset"
`define IO_CONF_LEN 35

`endif

// File: src/io_pkg.sv
// types shared by the i/o controller blocks
// opcode enum, received spi byte, input state and queue beat
package io_pkg;

	// opcodes sent by the io controller as the first byte of a transfer
	typedef enum logic [7:0] {
		cmd_but_sw    = 8'h01,
		cmd_joy0      = 8'h02,
		cmd_joy1      = 8'h03,
		cmd_mouse     = 8'h04,
		cmd_kbd       = 8'h05,
		cmd_conf_rd   = 8'h14,
		cmd_status    = 8'h15,
		cmd_analog    = 8'h1a,
		cmd_serial_rd = 8'h1b
	} io_cmd_e;

	// one byte off mosi with its position in the transfer
	// index saturates at 255, the opcode has index 0
	typedef struct packed {
		logic [7:0] data;
		logic [7:0] index;
		logic       valid;
	} spi_byte_t;

	// everything the host sets for the core
	// analog sticks carry x in the high byte
	typedef struct packed {
		logic [1:0]  buttons;
		logic [1:0]  switches;
		logic        scandoubler_disable;
		logic [7:0]  joystick_0;
		logic [7:0]  joystick_1;
		logic [15:0] joystick_analog_0;
		logic [15:0] joystick_analog_1;
	} input_state_t;

	// byte beat on a queue port, ready runs as its own wire
	typedef struct packed {
		logic [7:0] data;
		logic       valid;
	} queue_beat_t;

endpackage

// File: src/reply_mux.sv
// reply byte selection for host reads
// configuration string and serial flag/data interleave
`timescale 1ns/1ns
`include "io_defines.svh"

module reply_mux (
	input  io_pkg::spi_byte_t   rx,
	input  io_pkg::io_cmd_e     cmd,
	input  logic                load,
	output logic [7:0]          next_byte,
	input  io_pkg::queue_beat_t serial_head,
	output logic                serial_pop
);

	import io_pkg::*;

	// first character sits in the top byte
	localparam logic [8*`IO_CONF_LEN-1:0] conf_str = `IO_CONF_STR;

	// command in force for the byte being prepared
	io_cmd_e    cur_cmd;
	// number of the reply byte that follows, 1 after the opcode
	logic [8:0] slot;

	always_comb begin
		// opcode is not latched yet while it is still in rx
		cur_cmd    = (rx.index == 8'd0) ? io_cmd_e'(rx.data) : cmd;
		slot       = {1'b0, rx.index} + 9'd1;
		next_byte  = 8'h00;
		serial_pop = 1'b0;
		case (cur_cmd)
			cmd_conf_rd: begin
				// string runs out into zeros
				if (slot <= 9'(`IO_CONF_LEN))
					next_byte = conf_str[8 * (`IO_CONF_LEN - int'(slot)) +: 8];
			end
			cmd_serial_rd: begin
				if (slot[0]) begin
					// flag byte, bit 0 tells the host data follows
					next_byte = {7'b1000000, serial_head.valid};
				end else begin
					if (serial_head.valid)
						next_byte = serial_head.data;
					// pop only when the head actually goes out
					serial_pop = load && serial_head.valid;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: src/spi_frame.sv
// spi mode 0 framing for the i/o controller
// bit and byte counters, mosi deserializer, miso serializer
`timescale 1ns/1ns
`include "io_defines.svh"

module spi_frame (
	input  logic              spi_sck,
	input  logic              SPI_SS_IO,
	input  logic              spi_mosi,
	output logic              spi_miso,
	output io_pkg::spi_byte_t rx,
	input  logic [7:0]        next_byte,
	output logic              load
);

	// bit position within the current byte
	logic [2:0] bit_cnt;
	// byte position within the transfer, sticks at 255
	logic [7:0] byte_cnt;
	// first seven bits of the byte being received
	logic [6:0] sbuf;
	logic       rx_valid;
	logic [7:0] rx_data;
	logic [7:0] rx_index;
	// reply byte currently on its way out
	logic [7:0] tx_byte;

	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt  <= 3'd0;
			byte_cnt <= 8'd0;
			rx_valid <= 1'b0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			// one cycle pulse after the eighth bit
			rx_valid <= (bit_cnt == 3'd7);
			if ((bit_cnt == 3'd7) && (byte_cnt != 8'd255))
				byte_cnt <= byte_cnt + 8'd1;
		end
	end

	// msb first shift, the last bit goes straight into the byte
	always_ff @(posedge spi_sck) begin
		sbuf <= {sbuf[5:0], spi_mosi};
		if (bit_cnt == 3'd7) begin
			rx_data  <= {sbuf, spi_mosi};
			rx_index <= byte_cnt;
		end
	end

	assign rx = '{data: rx_data, index: rx_index, valid: rx_valid};

	// reply byte is taken in the cycle the received byte is valid
	assign load = rx_valid;

	// miso changes on falling edges so the host samples it on rising ones
	// the idle high level doubles as bit 7 of the core type
	always_ff @(negedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			tx_byte  <= `IO_CORE_TYPE;
			spi_miso <= 1'b1;
		end else if (load) begin
			tx_byte  <= next_byte;
			spi_miso <= next_byte[7];
		end else begin
			spi_miso <= tx_byte[~bit_cnt];
		end
	end

endmodule

// File: src/user_io_top.sv
// i/o controller spi slave, top level
// spi framing, command decoder, reply selection
// keyboard, mouse and serial queues
`timescale 1ns/1ns
`include "io_defines.svh"

module user_io_top (
	input  logic                 spi_sck,
	input  logic                 SPI_SS_IO,
	input  logic                 spi_mosi,
	output logic                 spi_miso,
	output io_pkg::input_state_t state,
	output logic [7:0]           status,
	output io_pkg::queue_beat_t  kbd_out,
	input  logic                 kbd_ready,
	output io_pkg::queue_beat_t  mouse_out,
	input  logic                 mouse_ready,
	input  io_pkg::queue_beat_t  serial_in,
	output logic                 serial_ready
);

	import io_pkg::*;

	// serial queue is deeper, the host polls it less often
	localparam int SERIAL_QUEUE_BITS = 4;

	spi_byte_t   rx;
	logic        load;
	logic [7:0]  next_byte;
	io_cmd_e     cmd;
	queue_beat_t kbd_in;
	logic        kbd_in_ready;
	queue_beat_t mouse_in;
	logic        mouse_in_ready;
	queue_beat_t serial_head;
	logic        serial_pop;
	logic        flush;

	// status bit 0 is the controller's core reset and holds all queues empty
	assign flush = status[0];

	spi_frame u_frame (
		.spi_sck   (spi_sck),
		.SPI_SS_IO (SPI_SS_IO),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso),
		.rx        (rx),
		.next_byte (next_byte),
		.load      (load)
	);

	cmd_decoder u_decoder (
		.spi_sck        (spi_sck),
		.SPI_SS_IO      (SPI_SS_IO),
		.rx             (rx),
		.cmd            (cmd),
		.state          (state),
		.status         (status),
		.kbd_in         (kbd_in),
		.kbd_in_ready   (kbd_in_ready),
		.mouse_in       (mouse_in),
		.mouse_in_ready (mouse_in_ready)
	);

	reply_mux u_reply (
		.rx          (rx),
		.cmd         (cmd),
		.load        (load),
		.next_byte   (next_byte),
		.serial_head (serial_head),
		.serial_pop  (serial_pop)
	);

	// host to core keyboard bytes
	byte_fifo #(.DEPTH_BITS(`IO_QUEUE_BITS)) u_kbd_fifo (
		.spi_sck   (spi_sck),
		.flush     (flush),
		.in_beat   (kbd_in),
		.in_ready  (kbd_in_ready),
		.out_beat  (kbd_out),
		.out_ready (kbd_ready)
	);

	// host to core mouse bytes
	byte_fifo #(.DEPTH_BITS(`IO_QUEUE_BITS)) u_mouse_fifo (
		.spi_sck   (spi_sck),
		.flush     (flush),
		.in_beat   (mouse_in),
		.in_ready  (mouse_in_ready),
		.out_beat  (mouse_out),
		.out_ready (mouse_ready)
	);

	// core to host serial bytes, drained by cmd_serial_rd
	byte_fifo #(.DEPTH_BITS(SERIAL_QUEUE_BITS)) u_serial_fifo (
		.spi_sck   (spi_sck),
		.flush     (flush),
		.in_beat   (serial_in),
		.in_ready  (serial_ready),
		.out_beat  (serial_head),
		.out_ready (serial_pop)
	);

endmodule

// File: tb/user_io_props.sv
// concurrent checks bound to the i/o controller top level
// idle miso level, keyboard head stability, single cycle rx pulse
`timescale 1ns/1ns

module user_io_props (
	input logic                spi_sck,
	input logic                SPI_SS_IO,
	input logic                spi_miso,
	input io_pkg::spi_byte_t   rx,
	input io_pkg::queue_beat_t kbd_out,
	input logic                kbd_ready,
	input logic                flush
);

	// deselected device keeps miso high
	miso_idle_high: assert property (@(posedge spi_sck) SPI_SS_IO |-> spi_miso)
		else $error("spi_miso low while SPI_SS_IO is high");

	// back-pressure holds the keyboard head
	// a flush may drop it
	kbd_head_stable: assert property (
		@(posedge spi_sck) disable iff (flush)
		kbd_out.valid && !kbd_ready |=> $stable(kbd_out.data)
	) else $error("kbd_out data changed while stalled");

	// received byte pulse lasts one cycle
	rx_single_pulse: assert property (@(posedge spi_sck) rx.valid |=> !rx.valid)
		else $error("rx.valid high for two cycles");

endmodule

bind user_io_top user_io_props u_props (
	.spi_sck   (spi_sck),
	.SPI_SS_IO (SPI_SS_IO),
	.spi_miso  (spi_miso),
	.rx        (rx),
	.kbd_out   (kbd_out),
	.kbd_ready (kbd_ready),
	.flush     (flush)
);

// File: tb/user_io_tb.sv
// testbench for the i/o controller spi slave
// spi host driver with miso capture, keyboard/mouse/serial core models
// transfer table with expected replies, input state and queue heads
`timescale 1ns/1ns
`include "io_defines.svh"

module user_io_tb;

	import io_pkg::*;

	localparam int max_bytes   = 40;
	localparam int max_entries = 20;
	// usable slots of an input queue since one stays empty
	localparam int queue_room  = (1 << `IO_QUEUE_BITS) - 1;
	// usable slots of the serial queue with its four pointer bits
	localparam int serial_room = (1 << 4) - 1;
	// what the core models do around a transfer
	localparam int act_none        = 0;
	localparam int act_drain_kbd   = 1;
	localparam int act_drain_mouse = 2;
	localparam int act_push_serial = 3;
	localparam int act_fill_serial = 4;

	logic         spi_sck     = 1'b1;
	logic         SPI_SS_IO   = 1'b1;
	logic         spi_mosi    = 1'b0;
	logic         spi_miso;
	input_state_t state;
	logic [7:0]   status;
	queue_beat_t  kbd_out;
	logic         kbd_ready   = 1'b0;
	queue_beat_t  mouse_out;
	logic         mouse_ready = 1'b0;
	queue_beat_t  serial_in   = '0;
	logic         serial_ready;

	int unsigned  lcg_state = 85011;
	int           cycles = 0;
	int           cycle_limit = 0;
	string        conf_text;
	// reference model of what the host has set
	input_state_t exp_state;
	logic [7:0]   exp_status;
	logic [7:0]   exp_stick;
	logic [7:0]   kbd_q [$];
	logic [7:0]   mouse_q [$];
	logic [7:0]   ser_q [$];
	// one transfer with the opcode at 0
	logic [7:0]   tx_buf [max_bytes];
	logic [7:0]   rx_buf [max_bytes];
	logic [7:0]   exp_reply [max_bytes];
	// stimulus table
	io_cmd_e      tbl_op [max_entries];
	int           tbl_len [max_entries];
	int           tbl_act [max_entries];
	logic [7:0]   tbl_pay [max_entries][max_bytes];
	int           n_entries = 0;

	initial begin
		forever #2 spi_sck = ~spi_sck;
	end

	user_io_top dut (
		.spi_sck      (spi_sck),
		.SPI_SS_IO    (SPI_SS_IO),
		.spi_mosi     (spi_mosi),
		.spi_miso     (spi_miso),
		.state        (state),
		.status       (status),
		.kbd_out      (kbd_out),
		.kbd_ready    (kbd_ready),
		.mouse_out    (mouse_out),
		.mouse_ready  (mouse_ready),
		.serial_in    (serial_in),
		.serial_ready (serial_ready)
	);

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "run stopped at the first error");
	endtask

	// stuck transfers or drains end here
	always @(posedge spi_sck) begin
		cycles = cycles + 1;
		if ((cycle_limit > 0) && (cycles > cycle_limit))
			stop_with_failure("timeout: the run did not finish within its cycle limit");
	end

	task automatic check_state(input string name, input input_state_t got,
			input input_state_t want);
		if (got !== want)
			stop_with_failure($sformatf("CHECK FAILED time %0t ns: %s is %h, expected %h",
				$time, name, got, want));
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
		if (got !== want)
			stop_with_failure($sformatf("CHECK FAILED time %0t ns: %s is %h, expected %h",
				$time, name, got, want));
	endtask

	// data only matters on a valid beat
	task automatic check_beat(input string name, input queue_beat_t got, input queue_beat_t want);
		if ((got.valid !== want.valid) || (want.valid && (got.data !== want.data)))
			stop_with_failure($sformatf("CHECK FAILED time %0t ns: %s is %h, expected %h",
				$time, name, got, want));
	endtask

	// mode 0 host that changes mosi on falling edges and takes miso on rising ones
	task automatic spi_transfer(input int n);
		@(negedge spi_sck);
		SPI_SS_IO = 1'b0;
		for (int i = 0; i < n; i++) begin
			for (int b = 7; b >= 0; b--) begin
				spi_mosi = tx_buf[i][b];
				@(posedge spi_sck);
				rx_buf[i][b] = spi_miso;
				@(negedge spi_sck);
			end
		end
		// trailing clock so the last byte gets applied
		@(posedge spi_sck);
		@(negedge spi_sck);
		SPI_SS_IO = 1'b1;
		spi_mosi  = 1'b0;
	endtask

	task automatic idle_check(input int n);
		repeat (n) begin
			@(posedge spi_sck);
			check_byte("spi_miso while deselected", {7'd0, spi_miso}, 8'h01);
		end
	endtask

	// reply byte k of a transfer
	// serial data slots pop the model queue
	function automatic logic [7:0] predict_reply(input io_cmd_e op, input int k);
		if (op == cmd_conf_rd)
			return (k <= `IO_CONF_LEN) ? conf_text[k-1] : 8'h00;
		if (op == cmd_serial_rd) begin
			if (k % 2 == 1)
				return {7'b1000000, ser_q.size() != 0};
			if (ser_q.size() == 0)
				return 8'h00;
			return ser_q.pop_front();
		end
		return 8'h00;
	endfunction

	// payload byte k as the host command rules define it
	task automatic model_write(input io_cmd_e op, input int k, input logic [7:0] d);
		case (op)
			cmd_but_sw: begin
				exp_state.buttons             = d[1:0];
				exp_state.switches            = d[3:2];
				exp_state.scandoubler_disable = d[4];
			end
			cmd_joy0: exp_state.joystick_0 = d;
			cmd_joy1: exp_state.joystick_1 = d;
			cmd_status: begin
				exp_status = d;
				if (d[0]) begin
					kbd_q.delete();
					mouse_q.delete();
					ser_q.delete();
				end
			end
			cmd_analog: begin
				if (k == 1)
					exp_stick = d;
				else if ((k == 2) && (exp_stick == 8'd0))
					exp_state.joystick_analog_0[15:8] = d;
				else if ((k == 2) && (exp_stick == 8'd1))
					exp_state.joystick_analog_1[15:8] = d;
				else if ((k == 3) && (exp_stick == 8'd0))
					exp_state.joystick_analog_0[7:0] = d;
				else if ((k == 3) && (exp_stick == 8'd1))
					exp_state.joystick_analog_1[7:0] = d;
			end
			// a full queue drops the byte
			cmd_kbd: begin
				if ((exp_status[0] !== 1'b1) && (kbd_q.size() < queue_room))
					kbd_q.push_back(d);
			end
			cmd_mouse: begin
				if ((exp_status[0] !== 1'b1) && (mouse_q.size() < queue_room))
					mouse_q.push_back(d);
			end
			default: ;
		endcase
	endtask

	function automatic queue_beat_t expected_head(input bit use_mouse);
		queue_beat_t beat;
		beat.valid = use_mouse ? (mouse_q.size() != 0) : (kbd_q.size() != 0);
		beat.data  = 8'h00;
		if (beat.valid)
			beat.data = use_mouse ? mouse_q[0] : kbd_q[0];
		return beat;
	endfunction

	// core side drain with random stalls
	// head must hold until taken
	task automatic drain_queue(input bit use_mouse);
		queue_beat_t want;
		queue_beat_t got;
		logic [7:0]  r;
		string       name;
		if (use_mouse)
			name = "mouse_out";
		else
			name = "kbd_out";
		want = expected_head(use_mouse);
		while (want.valid) begin
			@(negedge spi_sck);
			got = use_mouse ? mouse_out : kbd_out;
			check_beat(name, got, want);
			r = lcg_next();
			if (use_mouse)
				mouse_ready = r[0];
			else
				kbd_ready = r[0];
			// taken on the next rising edge
			if (r[0] && use_mouse)
				void'(mouse_q.pop_front());
			else if (r[0])
				void'(kbd_q.pop_front());
			want = expected_head(use_mouse);
		end
		@(negedge spi_sck);
		kbd_ready   = 1'b0;
		mouse_ready = 1'b0;
		got = use_mouse ? mouse_out : kbd_out;
		check_beat(name, got, want);
	endtask

	// core pushes serial bytes and waits on ready for each
	task automatic push_serial(input int n);
		logic [7:0] b;
		for (int i = 0; i < n; i++) begin
			b = lcg_next();
			@(negedge spi_sck);
			serial_in = '{data: b, valid: 1'b1};
			while (!serial_ready)
				@(negedge spi_sck);
			ser_q.push_back(b);
		end
		@(negedge spi_sck);
		serial_in.valid = 1'b0;
	endtask

	// first >= 0 fixes payload byte 1 and the rest is random
	task automatic add_entry(input io_cmd_e op, input int len, input int act, input int first);
		tbl_op[n_entries]  = op;
		tbl_len[n_entries] = len;
		tbl_act[n_entries] = act;
		for (int k = 1; k <= len; k++)
			tbl_pay[n_entries][k] = lcg_next();
		if (first >= 0)
			tbl_pay[n_entries][1] = 8'(first);
		n_entries++;
	endtask

	initial begin
		int total;
		conf_text = `IO_CONF_STR;
		if (conf_text.len() != `IO_CONF_LEN)
			stop_with_failure("configuration string length differs from IO_CONF_LEN");
		// flush first so the queue pointers start from zero
		add_entry(cmd_status, 1, act_none, 1);
		add_entry(cmd_status, 1, act_none, 0);
		add_entry(cmd_but_sw, 1, act_none, -1);
		add_entry(cmd_joy0, 1, act_none, -1);
		add_entry(cmd_joy1, 1, act_none, -1);
		add_entry(cmd_analog, 3, act_none, 0);
		add_entry(cmd_analog, 3, act_none, 1);
		add_entry(cmd_analog, 3, act_none, 5);
		// two bytes past the queue room
		add_entry(cmd_kbd, 9, act_drain_kbd, -1);
		add_entry(cmd_mouse, 3, act_drain_mouse, -1);
		add_entry(cmd_conf_rd, `IO_CONF_LEN + 2, act_none, -1);
		add_entry(cmd_serial_rd, 4, act_none, -1);
		add_entry(cmd_serial_rd, 8, act_push_serial, -1);
		// keyboard bytes and a full serial queue left for the flush below
		add_entry(cmd_kbd, 2, act_fill_serial, -1);
		add_entry(cmd_status, 1, act_none, 1);
		add_entry(cmd_serial_rd, 2, act_none, -1);
		add_entry(cmd_status, 1, act_none, 0);
		add_entry(cmd_serial_rd, 2, act_none, -1);
		total = 0;
		for (int e = 0; e < n_entries; e++)
			total += 8 * (tbl_len[e] + 1) + 4;
		cycle_limit = 4 * total + 200;

		repeat (10) @(negedge spi_sck);
		for (int e = 0; e < n_entries; e++) begin
			if (tbl_act[e] == act_push_serial)
				push_serial(3);
			else if (tbl_act[e] == act_fill_serial)
				push_serial(serial_room);
			tx_buf[0]    = tbl_op[e];
			exp_reply[0] = `IO_CORE_TYPE;
			for (int k = 1; k <= tbl_len[e]; k++) begin
				tx_buf[k]    = tbl_pay[e][k];
				exp_reply[k] = predict_reply(tbl_op[e], k);
				model_write(tbl_op[e], k, tbl_pay[e][k]);
			end
			spi_transfer(tbl_len[e] + 1);
			for (int k = 0; k <= tbl_len[e]; k++)
				check_byte($sformatf("miso byte %0d of entry %0d", k, e),
					rx_buf[k], exp_reply[k]);
			idle_check(2);
			@(negedge spi_sck);
			check_state("state", state, exp_state);
			check_byte("status", status, exp_status);
			check_beat("kbd_out", kbd_out, expected_head(1'b0));
			check_beat("mouse_out", mouse_out, expected_head(1'b1));
			check_byte("serial_ready", {7'd0, serial_ready},
				{7'd0, ser_q.size() < serial_room});
			if (tbl_act[e] == act_drain_kbd)
				drain_queue(1'b0);
			else if (tbl_act[e] == act_drain_mouse)
				drain_queue(1'b1);
		end
		$display("Done: no errors");
		$finish;
	end

endmodule
